// ==== filelist.f ====
l2_geom_pkg.sv
l2_data_pkg.sv
sram_1r1w.sv
cache_lru.sv
l2_cache_arb.sv
l2_cache_tag.sv
l2_cache_read.sv
l2_cache.sv
l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - l2_geom_pkg.sv
  - l2_data_pkg.sv
  - sram_1r1w.sv
  - cache_lru.sv
  - l2_cache_arb.sv
  - l2_cache_tag.sv
  - l2_cache_read.sv
  - l2_cache.sv
  - target: test
    files:
      - l2_cache_tb.sv

// ==== l2_cache_tb.sv ====
/*
 * Table-driven testbench for the cache pipeline with a reference model.
 * A fill plus load step must be followed by a step without a fill, so the hold slot drains.
 * Responses and writebacks are matched in order. Cycle counts are not checked.
 */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb import l2_geom_pkg::*, l2_data_pkg::*;
();
	localparam int MAX_STEPS = 80;
	localparam int K_IDLE = 0;
	localparam int K_LOAD = 1;
	localparam int K_STORE = 2;
	localparam int K_FILL = 3;
	// Fill and load of the same address in one cycle
	localparam int K_FILL_LOAD = 4;

	logic clk;
	logic reset;
	logic req_en;
	logic req_store;
	l2_addr_t req_addr;
	l2_word_t req_wdata;
	logic fill_en;
	l2_addr_t fill_addr;
	l2_line_t fill_data;
	logic resp_valid;
	logic resp_hit;
	logic resp_store;
	l2_addr_t resp_addr;
	l2_word_t resp_rdata;
	logic wb_valid;
	l2_addr_t wb_addr;
	l2_line_t wb_data;

	// Step table, stimulus columns then expected columns
	string step_name[MAX_STEPS];
	int step_kind[MAX_STEPS];
	l2_addr_t step_addr[MAX_STEPS];
	l2_word_t step_wdata[MAX_STEPS];
	l2_line_t step_fill[MAX_STEPS];
	logic exp_hit[MAX_STEPS];
	l2_word_t exp_rdata[MAX_STEPS];
	l2_addr_t exp_wb_addr[MAX_STEPS];
	l2_line_t exp_wb_data[MAX_STEPS];
	int n_steps;
	bit built;
	integer seed;

	// Pending step indices, in issue order
	int resp_q[$];
	int wb_q[$];

	// Model state per set and way
	logic m_valid[L2_SETS][L2_WAYS];
	logic m_dirty[L2_SETS][L2_WAYS];
	l2_tag_t m_tag[L2_SETS][L2_WAYS];
	l2_line_t m_data[L2_SETS][L2_WAYS];
	int m_rank[L2_SETS][L2_WAYS];

	l2_cache #(
		.NUM_SETS(L2_SETS),
		.NUM_WAYS(L2_WAYS)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.req_en(req_en),
		.req_store(req_store),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.fill_en(fill_en),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_store(resp_store),
		.resp_addr(resp_addr),
		.resp_rdata(resp_rdata),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Word-aligned byte address
	function automatic l2_addr_t make_addr(input int tag, input int set, input int word);
		l2_addr_t a;
		a.tag = l2_tag_t'(tag);
		a.set_idx = l2_set_idx_t'(set);
		a.offset = {word[1:0], 2'b00};
		return a;
	endfunction

	function automatic l2_line_t random_line();
		l2_line_t line;
		for (int b = 0; b < WORDS_PER_LINE; b++)
			line[b] = $random(seed);
		return line;
	endfunction

	task automatic add_step(input string name, input int kind, input l2_addr_t addr,
		input l2_word_t wdata);
		step_name[n_steps] = name;
		step_kind[n_steps] = kind;
		step_addr[n_steps] = addr;
		step_wdata[n_steps] = wdata;
		// Every step draws a line, only fills use it
		step_fill[n_steps] = random_line();
		n_steps++;
	endtask

	task automatic build_table();
		logic [31:0] r;
		int kind;
		// Cold miss, then fill and hit on the very next cycle
		add_step("cold_load", K_LOAD, make_addr('h10, 1, 2), '0);
		add_step("fill_a", K_FILL, make_addr('h10, 1, 0), '0);
		add_step("load_after_fill", K_LOAD, make_addr('h10, 1, 2), '0);
		// Store hit touches one word only
		add_step("store_hit", K_STORE, make_addr('h10, 1, 1), 32'hcafe_0001);
		add_step("load_stored", K_LOAD, make_addr('h10, 1, 1), '0);
		add_step("load_neighbor", K_LOAD, make_addr('h10, 1, 2), '0);
		// No write-allocate, and the valid line in way 0 stays as it was
		add_step("store_miss", K_STORE, make_addr('h20, 1, 0), 32'hdead_beef);
		add_step("load_after_store_miss", K_LOAD, make_addr('h20, 1, 0), '0);
		add_step("load_a_word0", K_LOAD, make_addr('h10, 1, 0), '0);
		add_step("fill_b", K_FILL, make_addr('h20, 1, 0), '0);
		add_step("load_b", K_LOAD, make_addr('h20, 1, 0), '0);
		// Fill all four ways of set 5
		for (int t = 1; t <= 4; t++)
			add_step($sformatf("fill_set5_t%0d", t), K_FILL, make_addr(t, 5, 0), '0);
		// Hits reorder the LRU, t1 ends up dirty
		add_step("store_t1", K_STORE, make_addr(1, 5, 3), 32'h5a5a_0003);
		add_step("load_t2", K_LOAD, make_addr(2, 5, 0), '0);
		add_step("evict_clean_t3", K_FILL, make_addr(5, 5, 0), '0);
		add_step("evict_clean_t4", K_FILL, make_addr(6, 5, 0), '0);
		add_step("evict_dirty_t1", K_FILL, make_addr(7, 5, 0), '0);
		add_step("load_evicted_t1", K_LOAD, make_addr(1, 5, 3), '0);
		// Dirty line refilled in place, new data and no writeback
		add_step("store_t7", K_STORE, make_addr(7, 5, 1), 32'h7777_0001);
		add_step("refill_present", K_FILL, make_addr(7, 5, 0), '0);
		add_step("load_refilled", K_LOAD, make_addr(7, 5, 1), '0);
		// Request colliding with a fill is held behind it
		add_step("fill_with_load", K_FILL_LOAD, make_addr('h30, 7, 1), '0);
		add_step("drain_hold", K_IDLE, '0, '0);
		add_step("fill_with_load_evict", K_FILL_LOAD, make_addr(8, 5, 2), '0);
		add_step("drain_hold_2", K_IDLE, '0, '0);
		// Random mix over sets 8 to 11 with six tags
		for (int k = 0; k < 40; k++)
		begin
			r = $random(seed);
			case (r[1:0])
				2'd2: kind = K_STORE;
				2'd3: kind = K_FILL;
				default: kind = K_LOAD;
			endcase
			add_step($sformatf("rand_%0d", k), kind,
				make_addr('h40 + int'(r[6:4]) % 6, 8 + int'(r[9:8]), int'(r[11:10])),
				$random(seed));
		end
	endtask

	task automatic reset_model();
		for (int s = 0; s < L2_SETS; s++)
			for (int w = 0; w < L2_WAYS; w++)
			begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_rank[s][w] = w;
			end
	endtask

	function automatic int find_way(input l2_addr_t a);
		for (int w = 0; w < L2_WAYS; w++)
			if (m_valid[a.set_idx][w] && m_tag[a.set_idx][w] == a.tag)
				return w;
		return -1;
	endfunction

	// Touched way goes to the top, the ones above it slide down
	task automatic touch_way(input int s, input int way);
		int old;
		old = m_rank[s][way];
		for (int w = 0; w < L2_WAYS; w++)
			if (m_rank[s][w] > old)
				m_rank[s][w]--;
		m_rank[s][way] = L2_WAYS - 1;
	endtask

	task automatic predict_fill(input int i);
		l2_addr_t a;
		int s;
		int way;
		a = step_addr[i];
		s = a.set_idx;
		way = find_way(a);
		// Miss picks the lowest invalid way, else rank 0
		if (way < 0)
		begin
			for (int w = L2_WAYS - 1; w >= 0; w--)
				if (!m_valid[s][w])
					way = w;
			if (way < 0)
				for (int w = 0; w < L2_WAYS; w++)
					if (m_rank[s][w] == 0)
						way = w;
			if (m_valid[s][way] && m_dirty[s][way])
			begin
				exp_wb_addr[i] = {m_tag[s][way], a.set_idx, 4'h0};
				exp_wb_data[i] = m_data[s][way];
				wb_q.push_back(i);
			end
		end
		m_valid[s][way] = 1'b1;
		m_dirty[s][way] = 1'b0;
		m_tag[s][way] = a.tag;
		m_data[s][way] = step_fill[i];
		touch_way(s, way);
	endtask

	task automatic resolve_request(input int i);
		l2_addr_t a;
		int s;
		int way;
		int word;
		a = step_addr[i];
		s = a.set_idx;
		word = a.offset[3:2];
		way = find_way(a);
		exp_hit[i] = way >= 0;
		if (way >= 0)
		begin
			if (step_kind[i] == K_STORE)
			begin
				m_data[s][way][word] = step_wdata[i];
				m_dirty[s][way] = 1'b1;
			end
			else
				exp_rdata[i] = m_data[s][way][word];
			touch_way(s, way);
		end
		resp_q.push_back(i);
	endtask

	task automatic apply_step(input int i);
		int kind;
		kind = step_kind[i];
		req_en <= kind == K_LOAD || kind == K_STORE || kind == K_FILL_LOAD;
		req_store <= kind == K_STORE;
		req_addr <= step_addr[i];
		req_wdata <= step_wdata[i];
		fill_en <= kind == K_FILL || kind == K_FILL_LOAD;
		fill_addr <= step_addr[i];
		fill_data <= step_fill[i];
	endtask

	task automatic compare_field(input string step, input string field,
		input logic [127:0] expected, input logic [127:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] %s %s expected %0h actual %0h", step, field, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Outputs are registered on the rising edge, sample them mid-cycle
	always @(negedge clk)
	begin : monitor
		int idx;
		if (resp_valid)
		begin
			assert (resp_q.size() > 0)
			else
			begin
				$display("Response for address %h arrived with no request pending", resp_addr);
				$display("STATUS: FAIL");
				$fatal(1, "unexpected response");
			end
			idx = resp_q.pop_front();
			compare_field(step_name[idx], "hit", exp_hit[idx], resp_hit);
			compare_field(step_name[idx], "store", step_kind[idx] == K_STORE, resp_store);
			compare_field(step_name[idx], "addr", step_addr[idx], resp_addr);
			// Miss and store data come from an arbitrary way
			if (exp_hit[idx] && step_kind[idx] != K_STORE)
				compare_field(step_name[idx], "rdata", exp_rdata[idx], resp_rdata);
		end
		if (wb_valid)
		begin
			assert (wb_q.size() > 0)
			else
			begin
				$display("Writeback of address %h arrived although no line was dirty", wb_addr);
				$display("STATUS: FAIL");
				$fatal(1, "unexpected writeback");
			end
			idx = wb_q.pop_front();
			compare_field(step_name[idx], "wb_addr", exp_wb_addr[idx], wb_addr);
			compare_field(step_name[idx], "wb_data", exp_wb_data[idx], wb_data);
		end
	end

	initial
	begin
		reset = 1'b1;
		req_en = 1'b0;
		req_store = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		fill_en = 1'b0;
		fill_addr = '0;
		fill_data = '0;
		seed = 93193;
		n_steps = 0;
		build_table();
		reset_model();
		built = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < n_steps; i++)
		begin
			@(posedge clk);
			apply_step(i);
			// Fill is ahead of a colliding request in the pipe
			if (step_kind[i] == K_FILL || step_kind[i] == K_FILL_LOAD)
				predict_fill(i);
			if (step_kind[i] != K_FILL && step_kind[i] != K_IDLE)
				resolve_request(i);
		end
		@(posedge clk);
		req_en <= 1'b0;
		fill_en <= 1'b0;
		while (resp_q.size() != 0 || wb_q.size() != 0)
			@(posedge clk);
		// Give stray pulses a chance to show up
		repeat (4) @(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (built);
		#((n_steps + 20) * 100);
		$display("Timeout with %0d responses and %0d writebacks still pending",
			resp_q.size(), wb_q.size());
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end
endmodule

`default_nettype wire

// ==== l2_cache.sv ====
/*
 * Write-back set-associative cache pipeline top.
 * Misses are only reported; the outside decides whether to fill.
 * Outputs are single-cycle pulses with no back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

module l2_cache import l2_geom_pkg::*, l2_data_pkg::*;
#(
	parameter int NUM_SETS = L2_SETS,
	parameter int NUM_WAYS = L2_WAYS
)(
	input wire clk,
	input wire reset,
	input wire req_en,
	input wire req_store,
	input wire l2_addr_t req_addr,
	input wire l2_word_t req_wdata,
	input wire fill_en,
	input wire l2_addr_t fill_addr,
	input wire l2_line_t fill_data,
	output logic resp_valid,
	output logic resp_hit,
	output logic resp_store,
	output l2_addr_t resp_addr,
	output l2_word_t resp_rdata,
	output logic wb_valid,
	output l2_addr_t wb_addr,
	output l2_line_t wb_data
);

	// Arbitration to tag stage
	logic arb_valid;
	logic arb_is_fill;
	logic arb_store;
	l2_addr_t arb_addr;
	l2_word_t arb_wdata;
	l2_line_t arb_fill_data;

	// Tag stage to read stage
	logic tag_item_valid;
	logic tag_is_fill;
	logic tag_store;
	l2_addr_t tag_addr;
	l2_word_t tag_wdata;
	l2_line_t tag_fill_data;
	logic [NUM_WAYS-1:0] tag_valid;
	l2_tag_t tag_value[NUM_WAYS];
	logic [NUM_WAYS-1:0] tag_dirty;
	l2_way_idx_t lru_victim;

	// Read stage back to tag stage
	logic [NUM_WAYS-1:0] update_tag_en;
	l2_set_idx_t update_set;
	logic update_valid;
	l2_tag_t update_tag;
	logic [NUM_WAYS-1:0] update_dirty_en;
	logic update_dirty_value;
	logic update_lru_en;
	l2_way_idx_t update_lru_way;

	l2_cache_arb arb_i (
		.clk,
		.reset,
		.req_en,
		.req_store,
		.req_addr,
		.req_wdata,
		.fill_en,
		.fill_addr,
		.fill_data,
		.arb_valid,
		.arb_is_fill,
		.arb_store,
		.arb_addr,
		.arb_wdata,
		.arb_fill_data
	);

	l2_cache_tag #(
		.NUM_SETS(NUM_SETS),
		.NUM_WAYS(NUM_WAYS)
	) tag_i (
		.clk,
		.reset,
		.arb_valid,
		.arb_is_fill,
		.arb_store,
		.arb_addr,
		.arb_wdata,
		.arb_fill_data,
		.update_tag_en,
		.update_set,
		.update_valid,
		.update_tag,
		.update_dirty_en,
		.update_dirty_value,
		.update_lru_en,
		.update_lru_way,
		.tag_item_valid,
		.tag_is_fill,
		.tag_store,
		.tag_addr,
		.tag_wdata,
		.tag_fill_data,
		.tag_valid,
		.tag_value,
		.tag_dirty,
		.lru_victim
	);

	l2_cache_read #(
		.NUM_SETS(NUM_SETS),
		.NUM_WAYS(NUM_WAYS)
	) read_i (
		.clk,
		.reset,
		.tag_item_valid,
		.tag_is_fill,
		.tag_store,
		.tag_addr,
		.tag_wdata,
		.tag_fill_data,
		.tag_valid,
		.tag_value,
		.tag_dirty,
		.lru_victim,
		.update_tag_en,
		.update_set,
		.update_valid,
		.update_tag,
		.update_dirty_en,
		.update_dirty_value,
		.update_lru_en,
		.update_lru_way,
		.resp_valid,
		.resp_hit,
		.resp_store,
		.resp_addr,
		.resp_rdata,
		.wb_valid,
		.wb_addr,
		.wb_data
	);
endmodule

`default_nettype wire

// ==== l2_cache_read.sv ====
/*
 * Read stage. Hit check, fill way choice, metadata updates and data banks.
 * Store misses are ignored (no write-allocate). Banks read old data, so a
 * fill sees the victim line it overwrites. Outputs lag by two registers.
 */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_read import l2_geom_pkg::*, l2_data_pkg::*;
#(
	parameter int NUM_SETS = L2_SETS,
	parameter int NUM_WAYS = L2_WAYS,
	localparam int BANK_ADDR_BITS = $clog2(NUM_SETS * NUM_WAYS)
)(
	input wire clk,
	input wire reset,

	// Item and metadata from the tag stage
	input wire tag_item_valid,
	input wire tag_is_fill,
	input wire tag_store,
	input wire l2_addr_t tag_addr,
	input wire l2_word_t tag_wdata,
	input wire l2_line_t tag_fill_data,
	input wire [NUM_WAYS-1:0] tag_valid,
	input wire l2_tag_t tag_value[NUM_WAYS],
	input wire [NUM_WAYS-1:0] tag_dirty,
	input wire l2_way_idx_t lru_victim,

	// Metadata updates back to the tag stage
	output logic [NUM_WAYS-1:0] update_tag_en,
	output l2_set_idx_t update_set,
	output logic update_valid,
	output l2_tag_t update_tag,
	output logic [NUM_WAYS-1:0] update_dirty_en,
	output logic update_dirty_value,
	output logic update_lru_en,
	output l2_way_idx_t update_lru_way,

	// Response and writeback
	output logic resp_valid,
	output logic resp_hit,
	output logic resp_store,
	output l2_addr_t resp_addr,
	output l2_word_t resp_rdata,
	output logic wb_valid,
	output l2_addr_t wb_addr,
	output l2_line_t wb_data
);

	logic [NUM_WAYS-1:0] hit_oh;
	logic hit;
	logic has_free;
	l2_way_idx_t hit_way;
	l2_way_idx_t free_way;
	l2_way_idx_t fill_way;
	l2_way_idx_t target_way;
	logic fill_go;
	logic store_hit;
	logic victim_dirty;
	l2_addr_t victim_addr;
	l2_word_idx_t word_idx;
	logic [BANK_ADDR_BITS-1:0] bank_addr;
	l2_line_t line_rd;

	// Stage register
	logic rd_resp;
	logic rd_wb;
	logic rd_hit;
	logic rd_store;
	l2_addr_t rd_addr;
	l2_addr_t rd_wb_addr;

	always_comb
	begin
		hit_way = '0;
		free_way = '0;
		has_free = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			hit_oh[w] = tag_valid[w] && tag_value[w] == tag_addr.tag;
			if (hit_oh[w])
				hit_way = l2_way_idx_t'(w);
		end
		// Walk downward so the lowest invalid way wins
		for (int w = NUM_WAYS - 1; w >= 0; w--)
		begin
			if (!tag_valid[w])
			begin
				has_free = 1'b1;
				free_way = l2_way_idx_t'(w);
			end
		end
	end

	assign hit = |hit_oh;
	assign fill_way = hit ? hit_way : (has_free ? free_way : lru_victim);
	assign target_way = tag_is_fill ? fill_way : hit_way;
	assign fill_go = tag_item_valid && tag_is_fill;
	assign store_hit = tag_item_valid && !tag_is_fill && tag_store && hit;
	assign word_idx = tag_addr.offset[OFFSET_BITS-1:2];
	assign bank_addr = {target_way, tag_addr.set_idx};

	// Refilling a present line never writes back
	assign victim_dirty = fill_go && !hit && tag_valid[fill_way] && tag_dirty[fill_way];
	assign victim_addr = '{tag: tag_value[fill_way], set_idx: tag_addr.set_idx, offset: '0};

	always_comb
	begin
		update_tag_en = '0;
		update_dirty_en = '0;
		if (fill_go)
		begin
			update_tag_en[fill_way] = 1'b1;
			update_dirty_en[fill_way] = 1'b1;
		end
		else if (store_hit)
			update_dirty_en[hit_way] = 1'b1;
	end

	assign update_set = tag_addr.set_idx;
	assign update_valid = 1'b1;
	assign update_tag = tag_addr.tag;
	// Fill installs clean, store marks dirty
	assign update_dirty_value = !tag_is_fill;
	assign update_lru_en = tag_item_valid && (tag_is_fill || hit);
	assign update_lru_way = target_way;

	// One bank per word position, entries indexed by way and set
	for (genvar b = 0; b < WORDS_PER_LINE; b++)
	begin : g_bank
		sram_1r1w #(
			.SIZE(NUM_SETS * NUM_WAYS),
			.DATA_T(l2_word_t),
			.READ_NEW(1'b0)
		) bank_i (
			.clk,
			.read_en(tag_item_valid),
			.read_addr(bank_addr),
			.read_data(line_rd[b]),
			.write_en(fill_go || (store_hit && word_idx == b)),
			.write_addr(bank_addr),
			.write_data(tag_is_fill ? tag_fill_data[b] : tag_wdata)
		);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_resp <= 1'b0;
			rd_wb <= 1'b0;
			resp_valid <= 1'b0;
			wb_valid <= 1'b0;
		end
		else
		begin
			rd_resp <= tag_item_valid && !tag_is_fill;
			rd_wb <= victim_dirty;
			resp_valid <= rd_resp;
			wb_valid <= rd_wb;
		end
	end

	always_ff @(posedge clk)
	begin
		rd_hit <= hit;
		rd_store <= tag_store;
		rd_addr <= tag_addr;
		rd_wb_addr <= victim_addr;
		// Bank data lands together with the stage register
		resp_hit <= rd_hit;
		resp_store <= rd_store;
		resp_addr <= rd_addr;
		resp_rdata <= line_rd[rd_addr.offset[OFFSET_BITS-1:2]];
		wb_addr <= rd_wb_addr;
		wb_data <= line_rd;
	end
endmodule

`default_nettype wire

// ==== l2_cache_tag.sv ====
/*
 * Tag stage. Reads per-way tag, dirty and valid state plus the LRU victim
 * for the set of the incoming item. Updates from the read stage in the
 * same cycle are visible, so back-to-back items to one set stay coherent.
 */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tag import l2_geom_pkg::*, l2_data_pkg::*;
#(
	parameter int NUM_SETS = L2_SETS,
	parameter int NUM_WAYS = L2_WAYS
)(
	input wire clk,
	input wire reset,

	// Item from arbitration
	input wire arb_valid,
	input wire arb_is_fill,
	input wire arb_store,
	input wire l2_addr_t arb_addr,
	input wire l2_word_t arb_wdata,
	input wire l2_line_t arb_fill_data,

	// Metadata updates from the read stage
	input wire [NUM_WAYS-1:0] update_tag_en,
	input wire l2_set_idx_t update_set,
	input wire update_valid,
	input wire l2_tag_t update_tag,
	input wire [NUM_WAYS-1:0] update_dirty_en,
	input wire update_dirty_value,
	input wire update_lru_en,
	input wire l2_way_idx_t update_lru_way,

	// Registered item and its metadata
	output logic tag_item_valid,
	output logic tag_is_fill,
	output logic tag_store,
	output l2_addr_t tag_addr,
	output l2_word_t tag_wdata,
	output l2_line_t tag_fill_data,
	output logic [NUM_WAYS-1:0] tag_valid,
	output l2_tag_t tag_value[NUM_WAYS],
	output logic [NUM_WAYS-1:0] tag_dirty,
	output l2_way_idx_t lru_victim
);

	// One valid bit per set and way
	logic [NUM_SETS-1:0] line_valid[NUM_WAYS];

	cache_lru #(
		.NUM_SETS(NUM_SETS),
		.NUM_WAYS(NUM_WAYS)
	) lru_i (
		.clk,
		.reset,
		.access_en(arb_valid),
		.access_set(arb_addr.set_idx),
		.update_en(update_lru_en),
		.update_set(update_set),
		.update_way(update_lru_way),
		.victim_way(lru_victim)
	);

	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_way
		// Tags, new data on a same-set update
		sram_1r1w #(
			.SIZE(NUM_SETS),
			.DATA_T(l2_tag_t),
			.READ_NEW(1'b1)
		) tag_sram_i (
			.clk,
			.read_en(arb_valid),
			.read_addr(arb_addr.set_idx),
			.read_data(tag_value[w]),
			.write_en(update_tag_en[w]),
			.write_addr(update_set),
			.write_data(update_tag)
		);

		sram_1r1w #(
			.SIZE(NUM_SETS),
			.DATA_T(logic),
			.READ_NEW(1'b1)
		) dirty_sram_i (
			.clk,
			.read_en(arb_valid),
			.read_addr(arb_addr.set_idx),
			.read_data(tag_dirty[w]),
			.write_en(update_dirty_en[w]),
			.write_addr(update_set),
			.write_data(update_dirty_value)
		);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int w = 0; w < NUM_WAYS; w++)
				line_valid[w] <= '0;
			tag_valid <= '0;
			tag_item_valid <= 1'b0;
			tag_is_fill <= 1'b0;
		end
		else
		begin
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				if (arb_valid)
				begin
					// Bypass a valid write to the same set
					if (update_tag_en[w] && update_set == arb_addr.set_idx)
						tag_valid[w] <= update_valid;
					else
						tag_valid[w] <= line_valid[w][arb_addr.set_idx];
				end
				if (update_tag_en[w])
					line_valid[w][update_set] <= update_valid;
			end
			tag_item_valid <= arb_valid;
			tag_is_fill <= arb_is_fill;
		end
	end

	// Item payload, qualified by tag_item_valid
	always_ff @(posedge clk)
	begin
		tag_store <= arb_store;
		tag_addr <= arb_addr;
		tag_wdata <= arb_wdata;
		tag_fill_data <= arb_fill_data;
	end
endmodule

`default_nettype wire

// ==== l2_cache_arb.sv ====
/*
 * Fill beats request. A losing request waits in a single hold slot.
 * The source must not issue a new request while the slot is occupied and a fill is present.
 */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_arb import l2_geom_pkg::*, l2_data_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire req_en,
	input wire req_store,
	input wire l2_addr_t req_addr,
	input wire l2_word_t req_wdata,
	input wire fill_en,
	input wire l2_addr_t fill_addr,
	input wire l2_line_t fill_data,
	output logic arb_valid,
	output logic arb_is_fill,
	output logic arb_store,
	output l2_addr_t arb_addr,
	output l2_word_t arb_wdata,
	output l2_line_t arb_fill_data
);

	logic hold_valid;
	logic hold_store;
	l2_addr_t hold_addr;
	l2_word_t hold_wdata;
	logic hold_load;

	// New request must wait behind a fill or an older held request
	assign hold_load = req_en && (fill_en || hold_valid);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			arb_valid <= 1'b0;
			arb_is_fill <= 1'b0;
			hold_valid <= 1'b0;
		end
		else
		begin
			arb_valid <= fill_en || hold_valid || req_en;
			arb_is_fill <= fill_en;
			// Slot drains only on a cycle without a fill
			hold_valid <= hold_load || (hold_valid && fill_en);
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_en)
		begin
			arb_store <= 1'b0;
			arb_addr <= fill_addr;
			arb_fill_data <= fill_data;
		end
		else if (hold_valid)
		begin
			arb_store <= hold_store;
			arb_addr <= hold_addr;
			arb_wdata <= hold_wdata;
		end
		else
		begin
			arb_store <= req_store;
			arb_addr <= req_addr;
			arb_wdata <= req_wdata;
		end

		if (hold_load)
		begin
			hold_store <= req_store;
			hold_addr <= req_addr;
			hold_wdata <= req_wdata;
		end
	end
endmodule

`default_nettype wire

// ==== cache_lru.sv ====
/*
 * True LRU per set kept as one rank per way, rank 0 is least recent.
 * An update in the same cycle as an access to that set is seen by the access.
 * Reset order is way 0 oldest up to the last way newest.
 */
`timescale 1ns/1ps
`default_nettype none

module cache_lru #(
	parameter int NUM_SETS = 16,
	parameter int NUM_WAYS = 4,
	localparam int SET_W = $clog2(NUM_SETS),
	localparam int WAY_W = $clog2(NUM_WAYS)
)(
	input wire clk,
	input wire reset,
	input wire access_en,
	input wire [SET_W-1:0] access_set,
	input wire update_en,
	input wire [SET_W-1:0] update_set,
	input wire [WAY_W-1:0] update_way,
	output logic [WAY_W-1:0] victim_way
);

	logic [WAY_W-1:0] rank[NUM_SETS][NUM_WAYS];
	logic [WAY_W-1:0] new_rank[NUM_WAYS];
	logic [WAY_W-1:0] access_rank[NUM_WAYS];
	logic [WAY_W-1:0] oldest_way;

	// Ranks of the updated set after the touched way moves to the top
	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (w == int'(update_way))
				new_rank[w] = WAY_W'(NUM_WAYS - 1);
			else if (rank[update_set][w] > rank[update_set][update_way])
				new_rank[w] = rank[update_set][w] - 1'b1;
			else
				new_rank[w] = rank[update_set][w];
		end
	end

	// Bypass, then pick the way with rank 0
	always_comb
	begin
		oldest_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (update_en && update_set == access_set)
				access_rank[w] = new_rank[w];
			else
				access_rank[w] = rank[access_set][w];
			if (access_rank[w] == '0)
				oldest_way = WAY_W'(w);
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				for (int w = 0; w < NUM_WAYS; w++)
					rank[s][w] <= WAY_W'(w);
			victim_way <= '0;
		end
		else
		begin
			if (update_en)
				rank[update_set] <= new_rank;
			if (access_en)
				victim_way <= oldest_way;
		end
	end
endmodule

`default_nettype wire

// ==== sram_1r1w.sv ====
/*
 * One read port and one write port, read data registered on read_en.
 * READ_NEW picks written or stored data when both ports hit one entry.
 * Contents are undefined after power-up.
 */
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w #(
	parameter int SIZE = 16,
	parameter type DATA_T = logic,
	parameter bit READ_NEW = 1'b0,
	localparam int ADDR_BITS = $clog2(SIZE)
)(
	input wire clk,
	input wire read_en,
	input wire [ADDR_BITS-1:0] read_addr,
	output DATA_T read_data,
	input wire write_en,
	input wire [ADDR_BITS-1:0] write_addr,
	input wire DATA_T write_data
);

	DATA_T mem[SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;

		if (read_en)
		begin
			// Same entry written this cycle
			if (READ_NEW && write_en && write_addr == read_addr)
				read_data <= write_data;
			else
				read_data <= mem[read_addr];
		end
	end
endmodule

`default_nettype wire

// ==== l2_data_pkg.sv ====
/*
 * Word and line payloads. Word 0 of a line sits in the low bits.
 * Word index is taken from byte address bits 3:2.
 */
`default_nettype none

package l2_data_pkg;
	localparam int WORDS_PER_LINE = 4;

	typedef logic [31:0] l2_word_t;
	typedef l2_word_t [WORDS_PER_LINE-1:0] l2_line_t;
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] l2_word_idx_t;
endpackage

`default_nettype wire

// ==== l2_geom_pkg.sv ====
/*
 * Cache geometry and byte address layout for a 32-bit address space.
 * Sizes here must agree with the NUM_SETS and NUM_WAYS module parameters.
 */
`default_nettype none

package l2_geom_pkg;
	localparam int L2_SETS = 16;
	localparam int L2_WAYS = 4;
	localparam int OFFSET_BITS = 4;
	localparam int SET_BITS = 4;
	// Whatever is left of the 32-bit address
	localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

	typedef logic [SET_BITS-1:0] l2_set_idx_t;
	typedef logic [$clog2(L2_WAYS)-1:0] l2_way_idx_t;
	typedef logic [TAG_BITS-1:0] l2_tag_t;

	// Tag in the upper bits, byte offset in the lower bits
	typedef struct packed {
		l2_tag_t tag;
		l2_set_idx_t set_idx;
		logic [OFFSET_BITS-1:0] offset;
	} l2_addr_t;
endpackage

`default_nettype wire
